// File: hdl/dll_rx_cfg.svh
`ifndef DLL_RX_CFG_SVH
`define DLL_RX_CFG_SVH

// --------------------------------------------------
// link layer widths
// --------------------------------------------------
`define DLL_PIPE_W      256         // one PIPE beat
`define DLL_CREDIT_W    12          // credit counters
`define DLL_SEQ_W       12          // tlp sequence number, wraps at 4096
`define DLL_HDR_W       128         // header handed to the transaction layer

// --------------------------------------------------
// framing and crc
// --------------------------------------------------
`define DLL_DLLP_TOKEN  16'hACF0    // bits 15:0 of a dllp beat
`define DLL_CRC_POLY    16'h100B
`define DLL_CRC_INIT    16'hFFFF    // crc seed

`endif

// File: hdl/dll_rx_pkg.sv
`default_nettype none

`include "dll_rx_cfg.svh"

package dll_rx_pkg;

    // --------------------------------------------------
    // input stream
    // --------------------------------------------------
    typedef struct packed {
        logic                    valid;
        logic [`DLL_PIPE_W-1:0]  data;
    } pipe_beat_t;

    // --------------------------------------------------
    // dllp decode
    // --------------------------------------------------
    typedef enum logic [1:0] {
        FC_P   = 2'd0,
        FC_NP  = 2'd1,
        FC_CPL = 2'd2
    } fc_class_e;

    // class index sits in bits 5:4 of the fc codes
    typedef enum logic [7:0] {
        DLLP_ACK         = 8'h00,
        DLLP_NAK         = 8'h10,
        DLLP_INITFC1_P   = 8'h40,
        DLLP_INITFC1_NP  = 8'h50,
        DLLP_INITFC1_CPL = 8'h60,
        DLLP_INITFC2_P   = 8'hC0,
        DLLP_INITFC2_NP  = 8'hD0,
        DLLP_INITFC2_CPL = 8'hE0,
        DLLP_UPDFC_P     = 8'h80,
        DLLP_UPDFC_NP    = 8'h90,
        DLLP_UPDFC_CPL   = 8'hA0
    } dllp_type_e;

    typedef struct packed {
        logic                   valid;
        dllp_type_e             dtype;
        logic [7:0]             hdr_credit;
        logic [`DLL_SEQ_W-1:0]  data_field;     // data credit or ack/nak seq
    } dllp_evt_t;

    // --------------------------------------------------
    // link status
    // --------------------------------------------------
    typedef struct packed {
        logic [`DLL_CREDIT_W-1:0]  hdr;
        logic [`DLL_CREDIT_W-1:0]  data;
    } fc_credit_t;

    typedef struct packed {
        fc_credit_t  lim_p;
        fc_credit_t  lim_np;                    // data part stays zero
        fc_credit_t  lim_cpl;
        fc_credit_t  cons_p;
        fc_credit_t  cons_np;                   // data part stays zero
        fc_credit_t  cons_cpl;
    } fc_status_t;

    typedef struct packed {
        logic                   ack;
        logic                   nak;
        logic [`DLL_SEQ_W-1:0]  seq;
    } acknak_t;

    typedef struct packed {
        logic                   valid;
        logic [`DLL_HDR_W-1:0]  hdr;
    } tl_hdr_t;

endpackage

`default_nettype wire

// File: hdl/dllp_rx.sv
`default_nettype none
`timescale 1ns/1ps

`include "dll_rx_cfg.svh"

module dllp_rx (
    input  wire                          sclk,
    input  wire                          srst_n,
    input  wire dll_rx_pkg::pipe_beat_t  beat_i,     // valid already qualified by top
    output dll_rx_pkg::dllp_evt_t        evt_o
);
    import dll_rx_pkg::*;

    logic                   beat_vld_q;
    logic [63:16]           dllp_q;                 // body and crc
    logic [15:0]            crc_calc;
    logic                   crc_ok;

    logic                   evt_vld_q;
    dllp_type_e             type_q;
    logic [7:0]             hdr_cr_q;
    logic [`DLL_SEQ_W-1:0]  data_q;

    // msb-first crc-16 over the 32-bit body
    function automatic logic [15:0] crc16_body(input logic [31:0] body);
        logic [15:0] crc;
        crc = `DLL_CRC_INIT;
        for (int i = 31; i >= 0; i--) begin
            if (crc[15] ^ body[i]) begin
                crc = {crc[14:0], 1'b0} ^ `DLL_CRC_POLY;
            end else begin
                crc = {crc[14:0], 1'b0};
            end
        end
        return crc;
    endfunction

    // --------------------------------------------------
    // stage one: capture
    // --------------------------------------------------
    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            beat_vld_q <= 1'b0;
        end else begin
            beat_vld_q <= beat_i.valid;
        end
    end

    always_ff @(posedge sclk) begin
        if (beat_i.valid) begin
            dllp_q <= beat_i.data[63:16];
        end
    end

    // --------------------------------------------------
    // stage two: crc check and decode
    // --------------------------------------------------
    always_comb begin
        crc_calc = crc16_body(dllp_q[47:16]);
        crc_ok   = (dllp_q[63:48] == ~crc_calc);    // received crc is inverted
    end

    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            evt_vld_q <= 1'b0;
        end else begin
            evt_vld_q <= beat_vld_q && crc_ok;      // one pulse per good dllp
        end
    end

    always_ff @(posedge sclk) begin
        if (beat_vld_q) begin
            type_q   <= dllp_type_e'(dllp_q[23:16]);            // unknown codes kept
            hdr_cr_q <= {dllp_q[29:24], dllp_q[39:38]};
            data_q   <= {dllp_q[35:32], dllp_q[47:40]};
        end
    end

    assign evt_o = '{valid:      evt_vld_q,
                     dtype:      type_q,
                     hdr_credit: hdr_cr_q,
                     data_field: data_q};

endmodule

`default_nettype wire

// File: hdl/fc_credit_store.sv
`default_nettype none
`timescale 1ns/1ps

`include "dll_rx_cfg.svh"

module fc_credit_store (
    input  wire                          sclk,
    input  wire                          srst_n,
    input  wire dll_rx_pkg::dllp_evt_t   evt_i,
    output dll_rx_pkg::fc_status_t       fc_o,
    output logic [2:0]                   fc_update_o,        // p, np, cpl at bits 0, 1, 2
    output logic                         init1_received_o,
    output logic                         init2_received_o,
    output dll_rx_pkg::acknak_t          acknak_o
);
    import dll_rx_pkg::*;

    fc_class_e   cls;
    fc_credit_t  cred;
    fc_status_t  fc_q;
    logic [2:0]  init1_q;
    logic [2:0]  init2_q;
    logic [2:0]  upd_q;
    acknak_t     acknak_q;

    // --------------------------------------------------
    // event fields
    // --------------------------------------------------
    always_comb begin
        cls       = fc_class_e'(evt_i.dtype[5:4]);
        cred.hdr  = {{(`DLL_CREDIT_W-8){1'b0}}, evt_i.hdr_credit};
        cred.data = (cls == FC_NP) ? '0 : evt_i.data_field;   // np has no data credit
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            fc_q     <= '0;
            init1_q  <= '0;
            init2_q  <= '0;
            upd_q    <= '0;
            acknak_q <= '0;
        end else begin
            upd_q        <= '0;                     // pulses last one cycle
            acknak_q.ack <= 1'b0;
            acknak_q.nak <= 1'b0;
            if (evt_i.valid) begin
                case (evt_i.dtype)
                    DLLP_INITFC1_P, DLLP_INITFC1_NP, DLLP_INITFC1_CPL: begin
                        init1_q[cls] <= 1'b1;
                        case (cls)
                            FC_P:    fc_q.lim_p   <= cred;
                            FC_NP:   fc_q.lim_np  <= cred;
                            default: fc_q.lim_cpl <= cred;
                        endcase
                    end
                    DLLP_INITFC2_P, DLLP_INITFC2_NP, DLLP_INITFC2_CPL: begin
                        init2_q[cls] <= 1'b1;
                    end
                    DLLP_UPDFC_P, DLLP_UPDFC_NP, DLLP_UPDFC_CPL: begin
                        upd_q[cls] <= 1'b1;
                        case (cls)
                            FC_P:    fc_q.cons_p   <= cred;
                            FC_NP:   fc_q.cons_np  <= cred;
                            default: fc_q.cons_cpl <= cred;
                        endcase
                    end
                    DLLP_ACK: begin
                        acknak_q.ack <= 1'b1;
                        acknak_q.seq <= evt_i.data_field;
                    end
                    DLLP_NAK: begin
                        acknak_q.nak <= 1'b1;
                        acknak_q.seq <= evt_i.data_field;
                    end
                    default: begin
                        // unsupported type, dropped
                    end
                endcase
            end
        end
    end

    assign fc_o             = fc_q;
    assign fc_update_o      = upd_q;
    assign init1_received_o = &init1_q;             // all three classes seen
    assign init2_received_o = &init2_q;
    assign acknak_o         = acknak_q;

endmodule

`default_nettype wire

// File: hdl/tlp_seq_check.sv
`default_nettype none
`timescale 1ns/1ps

`include "dll_rx_cfg.svh"

module tlp_seq_check (
    input  wire                          sclk,
    input  wire                          srst_n,
    input  wire dll_rx_pkg::pipe_beat_t  beat_i,     // valid already qualified by top
    output logic [`DLL_SEQ_W-1:0]        next_rcv_seq_o,
    output logic                         nak_scheduled_o,
    output dll_rx_pkg::tl_hdr_t          hdr_o
);

    logic                   beat_vld_q;
    logic [`DLL_SEQ_W-1:0]  rx_seq_q;
    logic [`DLL_HDR_W-1:0]  rx_hdr_q;
    logic                   seq_match;

    logic [`DLL_SEQ_W-1:0]  next_seq_q;
    logic                   nak_q;
    logic                   hdr_vld_q;
    logic [`DLL_HDR_W-1:0]  hdr_q;

    // --------------------------------------------------
    // stage one: capture
    // --------------------------------------------------
    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            beat_vld_q <= 1'b0;
        end else begin
            beat_vld_q <= beat_i.valid;
        end
    end

    always_ff @(posedge sclk) begin
        if (beat_i.valid) begin
            rx_seq_q <= {beat_i.data[19:16], beat_i.data[31:24]};
            rx_hdr_q <= beat_i.data[159:32];
        end
    end

    // --------------------------------------------------
    // stage two: sequence check
    // --------------------------------------------------
    always_comb begin
        seq_match = (rx_seq_q == next_seq_q);
    end

    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            next_seq_q <= '0;
            nak_q      <= 1'b0;
            hdr_vld_q  <= 1'b0;
        end else begin
            hdr_vld_q <= beat_vld_q && seq_match;
            if (beat_vld_q) begin
                if (seq_match) begin
                    next_seq_q <= next_seq_q + 1'b1;    // wraps at 4096
                    nak_q      <= 1'b0;
                end else begin
                    nak_q      <= 1'b1;                 // held until next good tlp
                end
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (beat_vld_q && seq_match) begin
            hdr_q <= rx_hdr_q;
        end
    end

    assign next_rcv_seq_o  = next_seq_q;
    assign nak_scheduled_o = nak_q;
    assign hdr_o           = '{valid: hdr_vld_q, hdr: hdr_q};

endmodule

`default_nettype wire

// File: hdl/dll_rx_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "dll_rx_cfg.svh"

module dll_rx_top (
    input  wire                          sclk,
    input  wire                          srst_n,
    input  wire dll_rx_pkg::pipe_beat_t  pipe_i,
    output dll_rx_pkg::fc_status_t       fc_o,
    output logic [2:0]                   fc_update_o,
    output logic                         init1_received_o,
    output logic                         init2_received_o,
    output dll_rx_pkg::acknak_t          acknak_o,
    output logic [`DLL_SEQ_W-1:0]        next_rcv_seq_o,
    output logic                         nak_scheduled_o,
    output dll_rx_pkg::tl_hdr_t          tl_hdr_o
);
    import dll_rx_pkg::*;

    logic        is_dllp;
    logic        is_tlp;
    pipe_beat_t  dllp_beat;
    pipe_beat_t  tlp_beat;
    dllp_evt_t   dllp_evt;

    // --------------------------------------------------
    // beat routing
    // --------------------------------------------------
    always_comb begin
        is_dllp = pipe_i.valid && (pipe_i.data[15:0] == `DLL_DLLP_TOKEN);
        is_tlp  = pipe_i.valid && !is_dllp && (pipe_i.data[3:0] == 4'hF);  // header-only tlp

        dllp_beat = '{valid: is_dllp, data: pipe_i.data};
        tlp_beat  = '{valid: is_tlp,  data: pipe_i.data};
    end

    // --------------------------------------------------
    // dllp path
    // --------------------------------------------------
    dllp_rx u_dllp_rx (
        .sclk   (sclk),
        .srst_n (srst_n),
        .beat_i (dllp_beat),
        .evt_o  (dllp_evt)
    );

    fc_credit_store u_fc_credit_store (
        .sclk             (sclk),
        .srst_n           (srst_n),
        .evt_i            (dllp_evt),
        .fc_o             (fc_o),
        .fc_update_o      (fc_update_o),
        .init1_received_o (init1_received_o),
        .init2_received_o (init2_received_o),
        .acknak_o         (acknak_o)
    );

    // --------------------------------------------------
    // tlp path
    // --------------------------------------------------
    tlp_seq_check u_tlp_seq_check (
        .sclk            (sclk),
        .srst_n          (srst_n),
        .beat_i          (tlp_beat),
        .next_rcv_seq_o  (next_rcv_seq_o),
        .nak_scheduled_o (nak_scheduled_o),
        .hdr_o           (tl_hdr_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_dll_rx_vectors.svh
`ifndef TB_DLL_RX_VECTORS_SVH
`define TB_DLL_RX_VECTORS_SVH

localparam logic DLLP    = 1'b0;
localparam logic TLP     = 1'b1;
localparam int   NUM_VEC = 17;

// one row per test, expected values hold at the check point
typedef struct packed {
    logic        kind;
    logic [7:0]  dtype;                 // unused for a tlp
    logic        bad_crc;               // flips one received crc bit
    logic [11:0] field;                 // ack/nak seq or tlp seq, fc credits drawn later
    logic [2:0]  exp_upd;
    logic        exp_init1;
    logic        exp_init2;
    logic        exp_ack;
    logic        exp_nak;
    logic        exp_hdr_vld;
    logic        exp_nak_sched;
    logic [11:0] exp_next_seq;
} vec_t;

string names[NUM_VEC];
vec_t  vecs[NUM_VEC];
int    vec_cnt;

task automatic add_vec(input string name, input vec_t v);
    names[vec_cnt] = name;
    vecs[vec_cnt]  = v;
    vec_cnt++;
endtask

task automatic load_vectors();
    vec_cnt = 0;
    // kind, type, bad crc, field, update, init1, init2, ack, nak,
    // hdr valid, nak scheduled, next seq
    add_vec("initfc1_p",   '{DLLP, DLLP_INITFC1_P,   0, 0, 3'b000, 0, 0, 0, 0, 0, 0, 0});
    add_vec("initfc1_np",  '{DLLP, DLLP_INITFC1_NP,  0, 0, 3'b000, 0, 0, 0, 0, 0, 0, 0});
    add_vec("initfc1_cpl", '{DLLP, DLLP_INITFC1_CPL, 0, 0, 3'b000, 1, 0, 0, 0, 0, 0, 0});
    add_vec("initfc2_p",   '{DLLP, DLLP_INITFC2_P,   0, 0, 3'b000, 1, 0, 0, 0, 0, 0, 0});
    add_vec("initfc2_np",  '{DLLP, DLLP_INITFC2_NP,  0, 0, 3'b000, 1, 0, 0, 0, 0, 0, 0});
    add_vec("initfc2_cpl", '{DLLP, DLLP_INITFC2_CPL, 0, 0, 3'b000, 1, 1, 0, 0, 0, 0, 0});
    add_vec("updfc_p",     '{DLLP, DLLP_UPDFC_P,     0, 0, 3'b001, 1, 1, 0, 0, 0, 0, 0});
    add_vec("updfc_np",    '{DLLP, DLLP_UPDFC_NP,    0, 0, 3'b010, 1, 1, 0, 0, 0, 0, 0});
    add_vec("updfc_cpl",   '{DLLP, DLLP_UPDFC_CPL,   0, 0, 3'b100, 1, 1, 0, 0, 0, 0, 0});
    add_vec("bad_crc",     '{DLLP, DLLP_UPDFC_P,     1, 0, 3'b000, 1, 1, 0, 0, 0, 0, 0});
    add_vec("ack",         '{DLLP, DLLP_ACK, 0, 12'h5A3, 3'b000, 1, 1, 1, 0, 0, 0, 0});
    add_vec("nak",         '{DLLP, DLLP_NAK, 0, 12'h0C7, 3'b000, 1, 1, 0, 1, 0, 0, 0});
    add_vec("tlp_seq0",    '{TLP, 8'h00, 0, 0, 3'b000, 1, 1, 0, 0, 1, 0, 1});
    add_vec("tlp_seq1",    '{TLP, 8'h00, 0, 1, 3'b000, 1, 1, 0, 0, 1, 0, 2});
    add_vec("tlp_seq2",    '{TLP, 8'h00, 0, 2, 3'b000, 1, 1, 0, 0, 1, 0, 3});
    add_vec("tlp_bad_seq", '{TLP, 8'h00, 0, 7, 3'b000, 1, 1, 0, 0, 0, 1, 3});
    add_vec("tlp_seq3",    '{TLP, 8'h00, 0, 3, 3'b000, 1, 1, 0, 0, 1, 0, 4});
endtask

`endif

// File: tests/tb_dll_rx.sv
`default_nettype none
`timescale 1ns/1ps

`include "dll_rx_cfg.svh"

module tb_dll_rx;
    import dll_rx_pkg::*;

    localparam int unsigned SEED = 32'h48e2_b442;

    logic                   sclk;
    logic                   srst_n;
    pipe_beat_t             pipe_i;
    fc_status_t             fc_o;
    logic [2:0]             fc_update_o;
    logic                   init1_received_o;
    logic                   init2_received_o;
    acknak_t                acknak_o;
    logic [`DLL_SEQ_W-1:0]  next_rcv_seq_o;
    logic                   nak_scheduled_o;
    tl_hdr_t                tl_hdr_o;

    `include "tb_dll_rx_vectors.svh"

    localparam int TIMEOUT_CYC = NUM_VEC * 4 + 20;

    logic [7:0]             hdr_cr[NUM_VEC];        // random header credits
    fc_status_t             exp_fc[NUM_VEC];
    logic [`DLL_SEQ_W-1:0]  exp_seq[NUM_VEC];       // last ack/nak seq
    string                  cur_name;
    int                     cycle_cnt;
    int                     err_cnt;                // mismatches in the running test
    int                     pass_cnt;
    int                     fail_cnt;

    dll_rx_top dut_i (
        .sclk             (sclk),
        .srst_n           (srst_n),
        .pipe_i           (pipe_i),
        .fc_o             (fc_o),
        .fc_update_o      (fc_update_o),
        .init1_received_o (init1_received_o),
        .init2_received_o (init2_received_o),
        .acknak_o         (acknak_o),
        .next_rcv_seq_o   (next_rcv_seq_o),
        .nak_scheduled_o  (nak_scheduled_o),
        .tl_hdr_o         (tl_hdr_o)
    );

    always #2 sclk = ~sclk;

    always @(posedge sclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout: the test loop ran past %0d cycles", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    // --------------------------------------------------
    // beat building
    // --------------------------------------------------
    function automatic logic [15:0] dllp_crc(input logic [31:0] body);
        logic [15:0] r;
        logic        fb;
        r = `DLL_CRC_INIT;
        for (int k = 0; k < 32; k++) begin
            fb = r[15] ^ body[31-k];                // msb of the body goes first
            r  = r << 1;
            if (fb) begin
                r = r ^ `DLL_CRC_POLY;
            end
        end
        return r;
    endfunction

    function automatic logic [127:0] hdr_pattern(input int i);
        return {4{16'hB00C, 16'(i)}};
    endfunction

    function automatic pipe_beat_t make_beat(input int i);
        pipe_beat_t   b;
        logic [31:0]  body;
        logic [11:0]  f;
        f       = vecs[i].field;
        body    = {f[7:0], hdr_cr[i][1:0], 2'b00, f[11:8], 2'b00, hdr_cr[i][7:2], vecs[i].dtype};
        b       = '0;
        b.valid = 1'b1;
        if (vecs[i].kind == TLP) begin
            b.data[159:0] = {hdr_pattern(i), f[7:0], 4'h0, f[11:8], 16'h000F};
        end else begin
            b.data[63:0] = {~dllp_crc(body) ^ {15'd0, vecs[i].bad_crc}, body, `DLL_DLLP_TOKEN};
        end
        return b;
    endfunction

    task automatic check_val(input string what, input logic [159:0] exp_v,
                             input logic [159:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    initial begin
        fc_status_t             m_fc;
        logic [`DLL_SEQ_W-1:0]  m_seq;
        fc_credit_t             c;
        int unsigned            seed_ret;
        sclk      = 1'b0;
        srst_n    = 1'b0;
        pipe_i    = '0;
        cycle_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        seed_ret  = $urandom(SEED);
        load_vectors();

        // draw the fc credits, then the link status each row should leave
        m_fc  = '0;
        m_seq = '0;
        for (int i = 0; i < NUM_VEC; i++) begin
            hdr_cr[i] = '0;
            if (vecs[i].kind == DLLP && vecs[i].dtype != DLLP_ACK
                    && vecs[i].dtype != DLLP_NAK) begin
                hdr_cr[i]     = 8'($urandom);
                vecs[i].field = 12'($urandom);
            end
            c = '{hdr: {4'h0, hdr_cr[i]}, data: vecs[i].field};
            if (vecs[i].kind == DLLP && !vecs[i].bad_crc) begin
                case (vecs[i].dtype)
                    DLLP_INITFC1_P:     m_fc.lim_p    = c;
                    DLLP_INITFC1_NP:    m_fc.lim_np   = '{hdr: c.hdr, data: '0};
                    DLLP_INITFC1_CPL:   m_fc.lim_cpl  = c;
                    DLLP_UPDFC_P:       m_fc.cons_p   = c;
                    DLLP_UPDFC_NP:      m_fc.cons_np  = '{hdr: c.hdr, data: '0};
                    DLLP_UPDFC_CPL:     m_fc.cons_cpl = c;
                    DLLP_ACK, DLLP_NAK: m_seq         = vecs[i].field;
                    default: ;
                endcase
            end
            exp_fc[i]  = m_fc;
            exp_seq[i] = m_seq;
        end

        repeat (5) @(posedge sclk);
        @(negedge sclk);
        srst_n = 1'b1;

        for (int i = 0; i < NUM_VEC; i++) begin
            cur_name = names[i];
            err_cnt  = 0;
            pipe_i   = make_beat(i);
            @(negedge sclk);
            pipe_i   = '0;
            repeat ((vecs[i].kind == TLP) ? 1 : 2) @(negedge sclk);   // dllp has one more stage
            check_val("fc credits", exp_fc[i], fc_o);
            check_val("fc update", vecs[i].exp_upd, fc_update_o);
            check_val("init1", vecs[i].exp_init1, init1_received_o);
            check_val("init2", vecs[i].exp_init2, init2_received_o);
            check_val("ack", vecs[i].exp_ack, acknak_o.ack);
            check_val("nak", vecs[i].exp_nak, acknak_o.nak);
            check_val("acknak seq", exp_seq[i], acknak_o.seq);
            check_val("next seq", vecs[i].exp_next_seq, next_rcv_seq_o);
            check_val("nak scheduled", vecs[i].exp_nak_sched, nak_scheduled_o);
            check_val("hdr valid", vecs[i].exp_hdr_vld, tl_hdr_o.valid);
            if (vecs[i].exp_hdr_vld) begin
                check_val("hdr", hdr_pattern(i), tl_hdr_o.hdr);
            end
            if (err_cnt == 0) begin
                pass_cnt++;
                $display("test %s: ok", cur_name);
            end else begin
                fail_cnt++;
                $display("test %s: failed with %0d mismatches", cur_name, err_cnt);
            end
        end

        $display("%0d tests, %0d passed, %0d failed", NUM_VEC, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
+incdir+tests
hdl/dll_rx_pkg.sv
hdl/dllp_rx.sv
hdl/fc_credit_store.sv
hdl/tlp_seq_check.sv
hdl/dll_rx_top.sv
tests/tb_dll_rx.sv

// File: Bender.yml
package:
  name: dll_rx

export_include_dirs:
  - hdl

sources:
  - hdl/dll_rx_pkg.sv
  - hdl/dllp_rx.sv
  - hdl/fc_credit_store.sv
  - hdl/tlp_seq_check.sv
  - hdl/dll_rx_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dll_rx.sv
